// File: logic/frame_data_pkg.sv
package frame_data_pkg;

    // word address into external memory
    typedef logic [20:0] mem_addr_t;

    // two pixels per word, first pixel in bits 15:0
    typedef logic [31:0] mem_word_t;

    typedef logic [15:0] pixel_t;

    // one display queue entry
    typedef struct packed {
        logic   sof;   // first pixel of a frame only
        pixel_t pixel;
    } queue_entry_t;

endpackage

// File: logic/download_ctrl_pkg.sv
package download_ctrl_pkg;

    // one-hot controller states
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        REQUEST = 5'b00010,
        BURST   = 5'b00100,
        DRAIN   = 5'b01000,
        DONE    = 5'b10000
    } dl_state_t;

    // selects one of the two cache slots
    typedef logic slot_t;

endpackage

// File: logic/cache_if.sv
`timescale 1ns/1ps

interface cache_if;

    import download_ctrl_pkg::*;

    slot_t       wr_slot;      // slot receiving the current burst
    logic        wr_word_en;   // read_data valid, store it
    logic [1:0]  slot_full;    // one flag per slot
    slot_t       release_slot;
    logic        release_en;   // single cycle, slot drained

    modport ctrl (
        output wr_slot,
        output wr_word_en,
        input  slot_full
    );

    modport cache (
        input  wr_slot,
        input  wr_word_en,
        output slot_full,
        input  release_slot,
        input  release_en
    );

    modport unpack (
        input  slot_full,
        output release_slot,
        output release_en
    );

endinterface

// File: logic/frame_addr_gen.sv
`timescale 1ns/1ps

module frame_addr_gen #(
    parameter int MEMORY_BURST      = 32,
    parameter int FRAME_WIDTH       = 480,
    parameter int FRAME_HEIGHT      = 272,
    parameter int ORIG_FRAME_WIDTH  = 640,
    parameter int ORIG_FRAME_HEIGHT = 480
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  frame_data_pkg::mem_addr_t base_addr,
    input  logic                     step,
    output frame_data_pkg::mem_addr_t read_addr,
    output logic                     last_burst
);

    import frame_data_pkg::*;

    localparam int WORDS       = MEMORY_BURST / 4;
    localparam int LINE_WORDS  = ORIG_FRAME_WIDTH / 2;
    localparam int CROP_X      = (ORIG_FRAME_WIDTH - FRAME_WIDTH) / 2;
    localparam int CROP_Y      = (ORIG_FRAME_HEIGHT - FRAME_HEIGHT) / 2;
    localparam int CROP_OFFSET = CROP_Y * LINE_WORDS + CROP_X / 2;
    localparam int BPL         = FRAME_WIDTH / 2 / WORDS;       // bursts per line
    localparam int LINE_SKIP   = LINE_WORDS - FRAME_WIDTH / 2;  // margin words
    localparam int BW          = (BPL > 1) ? $clog2(BPL) : 1;
    localparam int LW          = (FRAME_HEIGHT > 1) ? $clog2(FRAME_HEIGHT) : 1;

    logic [BW-1:0] burst_cnt;
    logic [LW-1:0] line_cnt;
    logic          line_end;
    mem_addr_t     addr_inc;

    assign line_end   = (burst_cnt == BW'(BPL - 1));
    assign last_burst = line_end && (line_cnt == LW'(FRAME_HEIGHT - 1));

    // one adder, the increment jumps over the margin at a line end
    assign addr_inc = line_end ? mem_addr_t'(WORDS + LINE_SKIP) : mem_addr_t'(WORDS);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_addr <= '0;
            burst_cnt <= '0;
            line_cnt  <= '0;
        end else if (start) begin
            read_addr <= base_addr + mem_addr_t'(CROP_OFFSET);
            burst_cnt <= '0;
            line_cnt  <= '0;
        end else if (step) begin
            read_addr <= read_addr + addr_inc;
            if (line_end) begin
                burst_cnt <= '0;
                line_cnt  <= line_cnt + 1'b1;
            end else begin
                burst_cnt <= burst_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/burst_cache.sv
`timescale 1ns/1ps

module burst_cache #(
    parameter int MEMORY_BURST = 32,
    parameter int IDX_W        = $clog2(MEMORY_BURST / 4)
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  frame_data_pkg::mem_word_t read_data,
    cache_if.cache                    wr,
    input  download_ctrl_pkg::slot_t  rd_slot,
    input  logic [IDX_W-1:0]          rd_index,
    output frame_data_pkg::mem_word_t rd_word
);

    import frame_data_pkg::*;

    localparam int WORDS = MEMORY_BURST / 4;

    mem_word_t        mem [2*WORDS];
    logic [IDX_W-1:0] wr_idx [2];   // next word per slot
    logic [1:0]       full;

    assign wr.slot_full = full;

    // storage, slot is the top address bit
    always_ff @(posedge clk) begin
        if (wr.wr_word_en) begin
            mem[{wr.wr_slot, wr_idx[wr.wr_slot]}] <= read_data;
        end
        rd_word <= mem[{rd_slot, rd_index}];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full      <= 2'b00;
            wr_idx[0] <= '0;
            wr_idx[1] <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (wr.release_en && (wr.release_slot == s[0])) begin
                    full[s] <= 1'b0;
                end
                if (wr.wr_word_en && (wr.wr_slot == s[0])) begin
                    if (wr_idx[s] == IDX_W'(WORDS - 1)) begin
                        wr_idx[s] <= '0;
                        full[s]   <= 1'b1;   // burst complete
                    end else begin
                        wr_idx[s] <= wr_idx[s] + 1'b1;
                    end
                end
            end
        end
    end

    // the controller must wait for the unpacker before reusing a slot
    a_no_write_full : assert property (@(posedge clk) disable iff (!reset_n)
        wr.wr_word_en |-> !full[wr.wr_slot]);

endmodule

// File: logic/pixel_unpacker.sv
`timescale 1ns/1ps

module pixel_unpacker #(
    parameter int MEMORY_BURST = 32,
    parameter int IDX_W        = $clog2(MEMORY_BURST / 4)
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         frame_start,
    input  logic                         queue_full,
    output frame_data_pkg::queue_entry_t queue_data,
    output logic                         wr_en,
    output download_ctrl_pkg::slot_t     rd_slot,
    output logic [IDX_W-1:0]             rd_index,
    input  frame_data_pkg::mem_word_t    rd_word,
    cache_if.unpack                      rel,
    output logic                         all_drained
);

    import frame_data_pkg::*;
    import download_ctrl_pkg::*;

    localparam int WORDS = MEMORY_BURST / 4;

    logic   addr_ok;   // rd_word matches rd_slot/rd_index
    logic   half;      // upper pixel waiting in hold
    logic   pend;      // queue_data holds an unwritten entry
    logic   sof_pend;
    logic   rel_en;
    slot_t  rel_slot;
    pixel_t hold;
    logic   accept;
    logic   load_lo;
    logic   load_hi;

    assign wr_en   = pend && !queue_full;
    assign accept  = !pend || !queue_full;
    assign load_lo = addr_ok && !half && accept;
    assign load_hi = half && accept;

    assign rel.release_en   = rel_en;
    assign rel.release_slot = rel_slot;

    // true in the cycle the last entry leaves
    assign all_drained = !half && (rel.slot_full == 2'b00) && (!pend || wr_en);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_slot  <= 1'b0;
            rd_index <= '0;
            addr_ok  <= 1'b0;
            half     <= 1'b0;
            pend     <= 1'b0;
            sof_pend <= 1'b0;
            rel_en   <= 1'b0;
            rel_slot <= 1'b0;
        end else begin
            rel_en  <= 1'b0;
            addr_ok <= !load_lo && rel.slot_full[rd_slot];
            if (load_lo) begin
                half     <= 1'b1;
                sof_pend <= 1'b0;
                if (rd_index == IDX_W'(WORDS - 1)) begin
                    rd_index <= '0;
                    rd_slot  <= ~rd_slot;   // whole word set is consumed
                    rel_en   <= 1'b1;
                    rel_slot <= rd_slot;
                end else begin
                    rd_index <= rd_index + 1'b1;
                end
            end
            if (load_hi) begin
                half <= 1'b0;
            end
            if (load_lo || load_hi) begin
                pend <= 1'b1;
            end else if (wr_en) begin
                pend <= 1'b0;
            end
            if (frame_start) begin
                sof_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_lo) begin
            queue_data.sof   <= sof_pend;
            queue_data.pixel <= rd_word[15:0];
            hold             <= rd_word[31:16];
        end else if (load_hi) begin
            queue_data.sof   <= 1'b0;
            queue_data.pixel <= hold;
        end
    end

    // a drained slot is still marked full when handed back
    a_release_full : assert property (@(posedge clk) disable iff (!reset_n)
        rel_en |-> rel.slot_full[rel_slot]);

endmodule

// File: logic/download_ctrl.sv
`timescale 1ns/1ps

module download_ctrl #(
    parameter int MEMORY_BURST = 32
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   start,
    input  logic   read_ack,
    output logic   read_rq,
    output logic   mem_rd_en,
    output logic   addr_step,
    input  logic   last_burst,
    output logic   frame_busy,
    input  logic   all_drained,
    output logic   download_done,
    cache_if.ctrl  cache
);

    import download_ctrl_pkg::*;

    localparam int WORDS = MEMORY_BURST / 4;
    localparam int CW    = (WORDS > 1) ? $clog2(WORDS) : 1;

    dl_state_t state;
    logic [CW-1:0] rd_cnt;     // mem_rd_en cycles issued
    logic [CW-1:0] word_cnt;   // words stored
    logic          word_en;
    slot_t         wr_slot;
    logic          last_req;   // burst in flight is the frame's last
    logic          burst_end;

    assign cache.wr_slot    = wr_slot;
    assign cache.wr_word_en = word_en;

    assign burst_end  = word_en && (word_cnt == CW'(WORDS - 1));
    assign addr_step  = (state == REQUEST) && read_rq && read_ack;
    assign frame_busy = (state != IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= IDLE;
            read_rq       <= 1'b0;
            mem_rd_en     <= 1'b0;
            word_en       <= 1'b0;
            rd_cnt        <= '0;
            word_cnt      <= '0;
            wr_slot       <= 1'b0;
            last_req      <= 1'b0;
            download_done <= 1'b0;
        end else begin
            word_en       <= mem_rd_en;   // data follows the strobe by a cycle
            download_done <= 1'b0;
            if (word_en) begin
                word_cnt <= burst_end ? '0 : word_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        read_rq <= 1'b1;   // both slots are free here
                        state   <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (read_rq) begin
                        if (read_ack) begin
                            read_rq   <= 1'b0;
                            mem_rd_en <= 1'b1;
                            rd_cnt    <= '0;
                            last_req  <= last_burst;
                            state     <= BURST;
                        end
                    end else if (!cache.slot_full[wr_slot]) begin
                        read_rq <= 1'b1;
                    end
                end
                BURST: begin
                    if (mem_rd_en) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (rd_cnt == CW'(WORDS - 1)) begin
                            mem_rd_en <= 1'b0;
                        end
                    end
                    if (burst_end) begin
                        wr_slot <= ~wr_slot;
                        state   <= last_req ? DRAIN : REQUEST;
                    end
                end
                DRAIN: begin
                    if (all_drained) begin
                        download_done <= 1'b1;
                        state         <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // memory side request must not be withdrawn before it is taken
    a_rq_held : assert property (@(posedge clk) disable iff (!reset_n)
        (read_rq && !read_ack) |=> read_rq);

endmodule

// File: logic/frame_downloader.sv
`timescale 1ns/1ps

module frame_downloader #(
    parameter int MEMORY_BURST      = 32,
    parameter int FRAME_WIDTH       = 480,
    parameter int FRAME_HEIGHT      = 272,
    parameter int ORIG_FRAME_WIDTH  = 640,
    parameter int ORIG_FRAME_HEIGHT = 480
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start,
    input  logic                         queue_full,
    input  logic                         read_ack,
    input  frame_data_pkg::mem_addr_t    base_addr,
    input  frame_data_pkg::mem_word_t    read_data,
    output frame_data_pkg::queue_entry_t queue_data,
    output logic                         wr_en,
    output logic                         read_rq,
    output frame_data_pkg::mem_addr_t    read_addr,
    output logic                         mem_rd_en,
    output logic                         download_done
);

    import frame_data_pkg::*;
    import download_ctrl_pkg::*;

    localparam int IDX_W = $clog2(MEMORY_BURST / 4);

    logic             addr_step;
    logic             last_burst;
    logic             frame_busy;
    logic             frame_start;
    logic             all_drained;
    slot_t            rd_slot;
    logic [IDX_W-1:0] rd_index;
    mem_word_t        rd_word;

    cache_if cif ();

    assign frame_start = start && !frame_busy;   // start while busy is dropped

    download_ctrl #(.MEMORY_BURST(MEMORY_BURST)) u_ctrl (
        .clk(clk), .reset_n(reset_n), .start(start), .read_ack(read_ack),
        .read_rq(read_rq), .mem_rd_en(mem_rd_en), .addr_step(addr_step),
        .last_burst(last_burst), .frame_busy(frame_busy),
        .all_drained(all_drained), .download_done(download_done), .cache(cif.ctrl)
    );

    frame_addr_gen #(
        .MEMORY_BURST(MEMORY_BURST), .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT), .ORIG_FRAME_WIDTH(ORIG_FRAME_WIDTH),
        .ORIG_FRAME_HEIGHT(ORIG_FRAME_HEIGHT)
    ) u_addr (
        .clk(clk), .reset_n(reset_n), .start(frame_start), .base_addr(base_addr),
        .step(addr_step), .read_addr(read_addr), .last_burst(last_burst)
    );

    burst_cache #(.MEMORY_BURST(MEMORY_BURST), .IDX_W(IDX_W)) u_cache (
        .clk(clk), .reset_n(reset_n), .read_data(read_data), .wr(cif.cache),
        .rd_slot(rd_slot), .rd_index(rd_index), .rd_word(rd_word)
    );

    pixel_unpacker #(.MEMORY_BURST(MEMORY_BURST), .IDX_W(IDX_W)) u_unpack (
        .clk(clk), .reset_n(reset_n), .frame_start(frame_start),
        .queue_full(queue_full), .queue_data(queue_data), .wr_en(wr_en),
        .rd_slot(rd_slot), .rd_index(rd_index), .rd_word(rd_word),
        .rel(cif.unpack), .all_drained(all_drained)
    );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      read_rq,
    input  frame_data_pkg::mem_addr_t read_addr,
    input  logic                      mem_rd_en,
    input  int                        ack_delay,   // cycles before the next acknowledge
    output logic                      read_ack,
    output frame_data_pkg::mem_word_t read_data
);

    import frame_data_pkg::*;

    mem_addr_t cur;        // next word of the burst
    logic      rd_prev;
    logic      waiting;
    int        wait_cnt;

    // upper address bits fold into the lower pixel
    function automatic mem_word_t word_at(input mem_addr_t a);
        return {~a[15:0], a[15:0] ^ {a[20:16], 11'd0}};
    endfunction

    always @(negedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_ack  <= 1'b0;
            read_data <= '0;
            rd_prev   <= 1'b0;
            waiting   <= 1'b0;
            wait_cnt  <= 0;
            cur       <= '0;
        end else begin
            rd_prev  <= mem_rd_en;
            read_ack <= 1'b0;
            if (rd_prev) begin   // strobe was last cycle, data due now
                read_data <= word_at(cur);
                cur       <= cur + 1'b1;
            end
            if (read_rq && !read_ack) begin
                if (waiting && wait_cnt > 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else if (!waiting && ack_delay > 0) begin
                    waiting  <= 1'b1;
                    wait_cnt <= ack_delay - 1;
                end else begin
                    read_ack <= 1'b1;
                    waiting  <= 1'b0;
                    cur      <= read_addr;
                end
            end
        end
    end

endmodule

// File: tests/tb_frame_downloader.sv
`timescale 1ns/1ps

module tb_frame_downloader;

    import frame_data_pkg::*;

    localparam int OW      = 64;
    localparam int OH      = 8;
    localparam int FW      = 32;
    localparam int FH      = 4;
    localparam int BURST   = 32;
    localparam int WORDS   = BURST / 4;
    localparam int BPL     = FW / 2 / WORDS;   // bursts per line
    localparam int CROP_X  = (OW - FW) / 2;    // in pixels
    localparam int CROP_Y  = (OH - FH) / 2;
    localparam int PIXELS  = FW * FH;
    localparam int TIMEOUT = 5 * PIXELS * 8 + 1000;   // five frames over all tests

    logic         clk = 1'b0;
    logic         reset_n;
    logic         start;
    logic         queue_full;
    logic         read_ack;
    mem_addr_t    base_addr;
    mem_word_t    read_data;
    queue_entry_t queue_data;
    logic         wr_en;
    logic         read_rq;
    mem_addr_t    read_addr;
    logic         mem_rd_en;
    logic         download_done;
    int           ack_delay;

    bit           bp_mode;
    bit           dly_mode;
    queue_entry_t got_q[$];
    mem_addr_t    addr_q[$];
    int           done_cnt = 0;
    int           done_at = 0;   // entries seen when done pulsed
    int           checks = 0;
    int           errors = 0;
    int           cycles = 0;

    always #50 clk = ~clk;

    frame_downloader #(
        .MEMORY_BURST(BURST), .FRAME_WIDTH(FW), .FRAME_HEIGHT(FH),
        .ORIG_FRAME_WIDTH(OW), .ORIG_FRAME_HEIGHT(OH)
    ) dut (.*);

    mem_model mem (.*);

    // queue sink and request log
    always @(posedge clk) begin
        if (reset_n) begin
            if (wr_en) begin
                if (queue_full) begin
                    errors++;
                    $display("error at %0t: wr_en high while queue_full is set", $time);
                end
                got_q.push_back(queue_data);
            end
            if (read_rq && read_ack) addr_q.push_back(read_addr);
            if (download_done) begin
                done_cnt++;
                done_at = got_q.size();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run exceeded %0d cycles", TIMEOUT);
            $display("summary: %0d checks, %0d errors", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic mem_addr_t expected_addr(input mem_addr_t base, input int k);
        return base + mem_addr_t'((CROP_Y + k / BPL) * (OW / 2) + CROP_X / 2
                                  + (k % BPL) * WORDS);
    endfunction

    function automatic queue_entry_t expected_entry(input mem_addr_t base, input int n);
        mem_addr_t    a;
        queue_entry_t e;
        a = base + mem_addr_t'((CROP_Y + n / FW) * (OW / 2) + CROP_X / 2 + (n % FW) / 2);
        e.sof   = (n == 0);
        e.pixel = (n % 2 == 1) ? ~a[15:0] : a[15:0] ^ {a[20:16], 11'd0};
        return e;
    endfunction

    task automatic check_entry(input queue_entry_t got, input queue_entry_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got sof %b pixel %h, expected sof %b pixel %h",
                     $time, what, got.sof, got.pixel, exp.sof, exp.pixel);
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_random();
        forever begin
            @(negedge clk);
            queue_full <= bp_mode && ($urandom_range(2, 0) == 0);
            ack_delay  <= dly_mode ? int'($urandom_range(5, 0)) : 0;
        end
    endtask

    task automatic test_reset();
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_bit(read_rq, 1'b0, "read_rq after reset");
        check_bit(mem_rd_en, 1'b0, "mem_rd_en after reset");
        check_bit(wr_en, 1'b0, "wr_en after reset");
        check_bit(download_done, 1'b0, "download_done after reset");
    endtask

    task automatic check_frame(input mem_addr_t base);
        int n;
        check_count(got_q.size(), PIXELS, "queue entries");
        check_count(addr_q.size(), FH * BPL, "burst requests");
        check_count(done_cnt, 1, "download_done pulses");
        check_count(done_at, PIXELS, "entries before download_done");
        for (n = 0; n < got_q.size() && n < PIXELS; n++) begin
            check_entry(got_q[n], expected_entry(base, n), $sformatf("entry %0d", n));
        end
        for (n = 0; n < addr_q.size() && n < FH * BPL; n++) begin
            check_addr(addr_q[n], expected_addr(base, n), $sformatf("burst %0d", n));
        end
    endtask

    // one download, optionally with a stray start while busy
    task automatic run_frame(input mem_addr_t base, input bit bp, input bit dly,
                             input bit poke);
        got_q.delete();
        addr_q.delete();
        done_cnt = 0;
        done_at  = 0;
        bp_mode  <= bp;
        dly_mode <= dly;
        @(negedge clk);
        base_addr = base;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (poke) begin
            while (got_q.size() < 20) @(negedge clk);
            base_addr = base + 21'h40;   // must not be picked up
            start     = 1'b1;
            @(negedge clk);
            start     = 1'b0;
            base_addr = base;
        end
        while (done_cnt == 0) @(negedge clk);
        repeat (4) @(negedge clk);
        check_frame(base);
    endtask

    initial begin
        void'($urandom(56));
        reset_n    = 1'b0;
        start      = 1'b0;
        queue_full = 1'b0;
        base_addr  = '0;
        ack_delay  = 0;
        bp_mode    = 1'b0;
        dly_mode   = 1'b0;
        fork
            drive_random();
        join_none
        test_reset();
        run_frame(21'h0, 1'b0, 1'b0, 1'b0);       // plain frame
        run_frame(21'h0, 1'b1, 1'b0, 1'b0);       // queue back-pressure
        run_frame(21'h3a5, 1'b0, 1'b1, 1'b0);     // slow acks, shifted base
        run_frame(21'h200, 1'b1, 1'b1, 1'b1);
        run_frame(21'h1_0100, 1'b0, 1'b0, 1'b0);  // restart after done
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
logic/frame_data_pkg.sv
logic/download_ctrl_pkg.sv
logic/cache_if.sv
logic/frame_addr_gen.sv
logic/burst_cache.sv
logic/pixel_unpacker.sv
logic/download_ctrl.sv
logic/frame_downloader.sv
tests/mem_model.sv
tests/tb_frame_downloader.sv
